// File: design/cache_pkg.sv
// cache_pkg: widths, typedefs and state encodings shared by the direct-mapped
// read-only cache, its fill state machine and the backing memory model
`default_nettype none

package cache_pkg;

    typedef logic [15:0] addr_t;   // byte address on the 16-bit machine
    typedef logic [15:0] word_t;   // one data word, two bytes wide

    // a block is 8 words, so 16 bytes, and the offset field is 4 bits wide
    localparam int WORDS_PER_BLOCK = 8;   // words fetched per fill, one at a time
    localparam int OFFSET_BITS     = 4;   // byte offset inside a block, bit 0 is the byte lane

    // fill sequencer, idle until a miss and then waiting on the memory latency
    typedef enum logic {
        FILL_IDLE,                 // no fill in progress, memory sees the aligned miss block
        FILL_WAIT                  // counting latency and writing one word per count
    } fill_state_t;

    // processor side port controller
    typedef enum logic [2:0] {
        CTRL_IDLE,                 // waiting for req
        CTRL_LOOKUP,               // tag compare on addr, hit latches rdata
        CTRL_FILL,                 // miss handed to the fill FSM, waiting for fill_done
        CTRL_ACK,                  // rdata is latched, ack goes high on the way out
        CTRL_RELEASE               // ack held high until req is seen low
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: design/cache_fill_fsm.sv
// cache_fill_fsm: on a miss, fetches the 8 words of the aligned block from the
// fixed-latency memory, writes each into the data array and then writes the tag
`timescale 1ns/1ns
`default_nettype none

module cache_fill_fsm #(
    parameter int MEM_LATENCY = 4              // cycles from stable address to valid memory data
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              miss_detected,   // one-cycle pulse from the controller on a miss
    input  cache_pkg::addr_t  miss_address,    // address that missed, offset bits get cleared here
    output logic              fsm_busy,        // high while a fill is starting or running
    output logic              write_data_array,// one pulse per word that comes back
    output logic              write_tag_array, // pulse with the last word, also the fill_done strobe
    output cache_pkg::addr_t  memory_address,  // address presented to the memory pipeline
    output cache_pkg::addr_t  fill_word_addr   // write address for both arrays
);

    localparam int LAT_W  = $clog2(MEM_LATENCY + 1);
    localparam int WCNT_W = $clog2(cache_pkg::WORDS_PER_BLOCK);

    cache_pkg::fill_state_t state;
    logic [LAT_W-1:0]       lat_cnt;     // cycles the current fetch address has been on the bus
    logic [WCNT_W-1:0]      word_cnt;    // words already written into the data array
    cache_pkg::addr_t       fetch_addr;  // word being fetched, steps by 2 bytes
    cache_pkg::addr_t       block_base;  // miss address with its block offset cleared
    logic                   word_valid;  // mem_rdata belongs to fetch_addr this cycle
    logic                   last_word;   // the word being counted is the eighth one

    assign block_base = {miss_address[15:cache_pkg::OFFSET_BITS],
                         {cache_pkg::OFFSET_BITS{1'b0}}};

    // the memory returns data MEM_LATENCY cycles after it sees an address, so a word
    // is ready once its address has been on the bus for that many cycles
    assign word_valid = (state == cache_pkg::FILL_WAIT) && (lat_cnt == LAT_W'(MEM_LATENCY));
    assign last_word  = (word_cnt == WCNT_W'(cache_pkg::WORDS_PER_BLOCK - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= cache_pkg::FILL_IDLE;
            lat_cnt  <= '0;
            word_cnt <= '0;
        end else begin
            case (state)
                cache_pkg::FILL_IDLE: begin
                    if (miss_detected) begin
                        state    <= cache_pkg::FILL_WAIT;
                        lat_cnt  <= LAT_W'(1);                  // the miss cycle already showed the base address
                        word_cnt <= '0;
                    end
                end
                cache_pkg::FILL_WAIT: begin
                    if (word_valid) begin
                        lat_cnt  <= '0;                         // next address appears after this edge
                        word_cnt <= word_cnt + WCNT_W'(1);      // wraps to 0 after the eighth word
                        if (last_word) begin
                            state <= cache_pkg::FILL_IDLE;      // tag is written on this same edge
                        end
                    end else begin
                        lat_cnt <= lat_cnt + LAT_W'(1);
                    end
                end
                default: state <= cache_pkg::FILL_IDLE;
            endcase
        end
    end

    // fetch address register, loaded with the block base and stepped one word per write
    always_ff @(posedge clk) begin
        if ((state == cache_pkg::FILL_IDLE) && miss_detected) begin
            fetch_addr <= block_base;
        end else if (word_valid) begin
            fetch_addr <= fetch_addr + cache_pkg::addr_t'(2);   // next 16-bit word
        end
    end

    assign fsm_busy         = (state == cache_pkg::FILL_WAIT) || miss_detected; // rises with the miss itself
    assign write_data_array = word_valid;
    assign write_tag_array  = word_valid && last_word;           // last word and tag land together
    assign fill_word_addr   = fetch_addr;

    // in idle the memory already sees the aligned miss block, which saves the first cycle
    assign memory_address = (state == cache_pkg::FILL_WAIT) ? fetch_addr : block_base;

endmodule

`default_nettype wire

// File: design/tag_array.sv
// tag_array: one tag and one valid bit per direct-mapped line, compared
// combinationally against the lookup address and written when a fill completes
`timescale 1ns/1ns
`default_nettype none

module tag_array #(
    parameter int LINES = 16                   // number of cache lines, a power of two
) (
    input  logic              clk,
    input  logic              rst,
    input  cache_pkg::addr_t  lookup_addr,     // processor address under lookup
    input  logic              write_tag_array, // fill complete, mark the line valid
    input  cache_pkg::addr_t  fill_word_addr,  // any address inside the filled block
    output logic              hit              // indexed line is valid and its tag matches
);

    localparam int IDX_W = $clog2(LINES);
    localparam int TAG_W = 16 - cache_pkg::OFFSET_BITS - IDX_W;

    logic [TAG_W-1:0] tags [0:LINES-1];        // stored tags, only meaningful where valid is set
    logic [LINES-1:0] valid;                   // one bit per line, cleared by reset

    logic [IDX_W-1:0] lookup_idx;
    logic [TAG_W-1:0] lookup_tag;
    logic [IDX_W-1:0] fill_idx;
    logic [TAG_W-1:0] fill_tag;

    // address split is tag | index | byte offset, from the top bit down
    assign lookup_idx = lookup_addr[cache_pkg::OFFSET_BITS +: IDX_W];
    assign lookup_tag = lookup_addr[cache_pkg::OFFSET_BITS + IDX_W +: TAG_W];
    assign fill_idx   = fill_word_addr[cache_pkg::OFFSET_BITS +: IDX_W];
    assign fill_tag   = fill_word_addr[cache_pkg::OFFSET_BITS + IDX_W +: TAG_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;                       // cold cache, every lookup misses
        end else if (write_tag_array) begin
            valid[fill_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (write_tag_array) begin
            tags[fill_idx] <= fill_tag;        // replaces whatever block lived in this line
        end
    end

    assign hit = valid[lookup_idx] && (tags[lookup_idx] == lookup_tag);

endmodule

`default_nettype wire

// File: design/data_array.sv
// data_array: LINES x 8 words of cached data, written one word at a time by the
// fill state machine and read combinationally at the processor address
`timescale 1ns/1ns
`default_nettype none

module data_array #(
    parameter int LINES = 16                    // number of cache lines, a power of two
) (
    input  logic              clk,
    input  logic              write_data_array, // write strobe, one per fetched word
    input  cache_pkg::addr_t  fill_word_addr,   // address of the word being filled
    input  cache_pkg::word_t  write_data,       // word coming back from memory
    input  cache_pkg::addr_t  read_addr,        // processor address
    output cache_pkg::word_t  read_data         // word at read_addr, valid on a hit only
);

    localparam int IDX_W  = $clog2(LINES);
    localparam int WOFF_W = $clog2(cache_pkg::WORDS_PER_BLOCK);
    localparam int SLOT_W = IDX_W + WOFF_W;
    localparam int LSB    = cache_pkg::OFFSET_BITS - WOFF_W;   // skips the byte lane bit

    cache_pkg::word_t mem [0:LINES*cache_pkg::WORDS_PER_BLOCK-1];

    logic [SLOT_W-1:0] wr_slot;                 // {line index, word offset}
    logic [SLOT_W-1:0] rd_slot;

    assign wr_slot = fill_word_addr[LSB +: SLOT_W];
    assign rd_slot = read_addr[LSB +: SLOT_W];

    always_ff @(posedge clk) begin
        if (write_data_array) begin
            mem[wr_slot] <= write_data;
        end
    end

    assign read_data = mem[rd_slot];            // tag compare decides if this is usable

endmodule

`default_nettype wire

// File: design/main_memory.sv
// main_memory: behavioral backing store of 32K words with a fixed read latency,
// pipelined so a new address can be accepted every cycle
`timescale 1ns/1ns
`default_nettype none

module main_memory #(
    parameter int MEM_LATENCY = 4              // cycles from address to data, at least 1
) (
    input  logic              clk,
    input  cache_pkg::addr_t  memory_address,  // byte address, bit 0 ignored
    output cache_pkg::word_t  mem_rdata        // word for the address seen MEM_LATENCY cycles ago
);

    localparam int DEPTH = 32768;              // whole 16-bit byte space as 16-bit words

    cache_pkg::word_t mem [0:DEPTH-1];
    cache_pkg::addr_t addr_pipe [0:MEM_LATENCY-1];  // addresses in flight, oldest at the end

    // contents rule, the word at byte address a holds ~a with bit 0 cleared.
    // for word index i the byte address is {i, 0}, so the value is {~i, 0}
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = {~i[14:0], 1'b0};
        end
    end

    // one stage per cycle of latency, nothing stalls and nothing is dropped
    always_ff @(posedge clk) begin
        addr_pipe[0] <= memory_address;
        for (int s = 1; s < MEM_LATENCY; s++) begin
            addr_pipe[s] <= addr_pipe[s-1];
        end
    end

    // the read address is registered, so this behaves as a synchronous read at the last stage
    assign mem_rdata = mem[addr_pipe[MEM_LATENCY-1][15:1]];

endmodule

`default_nettype wire

// File: design/cache_controller.sv
// cache_controller: four-phase req/ack port on the processor side, tag match
// result handling, miss hand-off to the fill FSM and the return of read data
`timescale 1ns/1ns
`default_nettype none

module cache_controller (
    input  logic              clk,
    input  logic              rst,
    input  logic              req,           // processor request, addr stable while high
    input  cache_pkg::addr_t  addr,          // processor byte address
    output logic              ack,           // rdata valid, held until req drops
    output cache_pkg::word_t  rdata,         // read data returned to the processor
    input  logic              hit,           // from the tag array, for addr
    input  cache_pkg::word_t  read_data,     // from the data array, for addr
    input  logic              fsm_busy,      // fill FSM has taken the miss
    input  logic              fill_done,     // last word and tag written this cycle
    output logic              miss_detected, // one-cycle request for a block fill
    output cache_pkg::addr_t  miss_address   // address to fill from
);

    cache_pkg::ctrl_state_t state;

    // the miss request lasts exactly the one lookup cycle that misses
    assign miss_detected = (state == cache_pkg::CTRL_LOOKUP) && !hit;
    assign miss_address  = addr;             // addr is held stable for the whole request

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cache_pkg::CTRL_IDLE;
            ack   <= 1'b0;
        end else begin
            case (state)
                cache_pkg::CTRL_IDLE: begin
                    if (req) begin
                        state <= cache_pkg::CTRL_LOOKUP;   // ack is low here, so a new request is fine
                    end
                end
                cache_pkg::CTRL_LOOKUP: begin
                    if (hit) begin
                        state <= cache_pkg::CTRL_ACK;
                    end else if (fsm_busy) begin
                        state <= cache_pkg::CTRL_FILL;     // fill FSM has seen the miss pulse
                    end
                end
                cache_pkg::CTRL_FILL: begin
                    if (fill_done) begin
                        state <= cache_pkg::CTRL_LOOKUP;   // the repeated lookup now hits
                    end
                end
                cache_pkg::CTRL_ACK: begin
                    ack   <= 1'b1;                         // two edges after req was sampled on a hit
                    state <= cache_pkg::CTRL_RELEASE;
                end
                cache_pkg::CTRL_RELEASE: begin
                    if (!req) begin
                        ack   <= 1'b0;                     // drops on the edge that sees req low
                        state <= cache_pkg::CTRL_IDLE;
                    end
                end
                default: begin
                    state <= cache_pkg::CTRL_IDLE;
                    ack   <= 1'b0;
                end
            endcase
        end
    end

    // only a hit in lookup loads rdata, so it stays put through ack and release
    always_ff @(posedge clk) begin
        if ((state == cache_pkg::CTRL_LOOKUP) && hit) begin
            rdata <= read_data;
        end
    end

endmodule

`default_nettype wire

// File: design/cache_top.sv
// cache_top: direct-mapped read-only cache with its miss-fill sequencer and a
// fixed-latency backing memory, behind a four-phase req/ack processor port
`timescale 1ns/1ns
`default_nettype none

module cache_top #(
    parameter int LINES       = 16,            // cache lines, a power of two
    parameter int MEM_LATENCY = 4              // backing memory read latency in cycles
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              req,
    input  cache_pkg::addr_t  addr,
    output logic              ack,
    output cache_pkg::word_t  rdata
);

    logic             hit;
    cache_pkg::word_t read_data;
    logic             fsm_busy;
    logic             fill_done;               // tag write strobe, also tells the controller to retry
    logic             miss_detected;
    cache_pkg::addr_t miss_address;
    logic             write_data_array;
    cache_pkg::addr_t fill_word_addr;
    cache_pkg::addr_t memory_address;
    cache_pkg::word_t mem_rdata;

    cache_controller u_cache_controller (
        .clk(clk), .rst(rst), .req(req), .addr(addr), .ack(ack), .rdata(rdata),
        .hit(hit), .read_data(read_data), .fsm_busy(fsm_busy), .fill_done(fill_done),
        .miss_detected(miss_detected), .miss_address(miss_address)
    );

    cache_fill_fsm #(.MEM_LATENCY(MEM_LATENCY)) u_cache_fill_fsm (
        .clk(clk), .rst(rst), .miss_detected(miss_detected), .miss_address(miss_address),
        .fsm_busy(fsm_busy), .write_data_array(write_data_array),
        .write_tag_array(fill_done), .memory_address(memory_address),
        .fill_word_addr(fill_word_addr)
    );

    tag_array #(.LINES(LINES)) u_tag_array (
        .clk(clk), .rst(rst), .lookup_addr(addr), .write_tag_array(fill_done),
        .fill_word_addr(fill_word_addr), .hit(hit)
    );

    data_array #(.LINES(LINES)) u_data_array (
        .clk(clk), .write_data_array(write_data_array), .fill_word_addr(fill_word_addr),
        .write_data(mem_rdata), .read_addr(addr), .read_data(read_data)
    );

    main_memory #(.MEM_LATENCY(MEM_LATENCY)) u_main_memory (
        .clk(clk), .memory_address(memory_address), .mem_rdata(mem_rdata)
    );

endmodule

`default_nettype wire

// File: test/cache_tb.sv
// testbench for cache_top that runs four-phase reads and checks the read data against
// the memory contents rule, the hit and miss latency and the req/ack handshake
`timescale 1ns/1ns
`default_nettype none

module cache_tb;

    localparam int LINES          = 16;
    localparam int MEM_LATENCY    = 4;
    localparam int TIMEOUT_CYCLES = 200;                                  // per wait loop
    localparam int TAG_LSB        = cache_pkg::OFFSET_BITS + $clog2(LINES); // lowest tag bit
    localparam int MISS_MIN       = cache_pkg::WORDS_PER_BLOCK * MEM_LATENCY; // fill cycles alone
    localparam int HIT_LATENCY    = 2;                                    // edges from req sample to ack

    logic             clk = 1'b0;
    logic             rst;
    logic             req;
    cache_pkg::addr_t addr;
    logic             ack;
    cache_pkg::word_t rdata;

    int          value_errors    = 0;
    int          protocol_errors = 0;
    int          timeout_errors  = 0;
    logic        aborted         = 1'b0;       // set by a timeout so that later reads are skipped
    logic [31:0] rng             = 32'hd094b989;

    // previous-edge copies for the handshake monitor
    logic             rst_q   = 1'b0;
    logic             ack_q   = 1'b0;
    logic             req_q   = 1'b0;
    cache_pkg::word_t rdata_q = '0;

    cache_top #(.LINES(LINES), .MEM_LATENCY(MEM_LATENCY)) u_cache_top (
        .clk(clk), .rst(rst), .req(req), .addr(addr), .ack(ack), .rdata(rdata)
    );

    always #5 clk = ~clk;                      // 10 ns period

    // reference model where the word at byte address a is ~a with bit 0 cleared
    function automatic cache_pkg::word_t rule_value(input cache_pkg::addr_t a);
        return ~a & 16'hfffe;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_value(input string name, input cache_pkg::word_t expected,
                                input cache_pkg::word_t actual);
        value_errors++;
        $display("Fail %s: expected 'h%04h, actual 'h%04h", name, expected, actual);
    endtask

    task automatic report_latency(input string name, input int expected, input int actual);
        value_errors++;
        $display("Fail %s: expected %0d cycles, actual %0d cycles", name, expected, actual);
    endtask

    // performs one four-phase read and returns in lat the edges from the req sample to ack
    task automatic read_word(input string name, input cache_pkg::addr_t a, input int hold,
                             output int lat);
        int   n;
        logic seen;
        lat = -1;
        if (!aborted) begin
            @(negedge clk);
            addr = a;                          // held stable until ack has fallen
            req  = 1'b1;
            n    = 0;
            seen = 1'b0;
            while (!seen && n < TIMEOUT_CYCLES) begin
                @(negedge clk);
                n++;
                seen = ack;
            end
            if (!seen) begin
                timeout_errors++;
                aborted = 1'b1;
                req     = 1'b0;
                $display("%s: no ack within %0d cycles for address 'h%04h",
                         name, TIMEOUT_CYCLES, a);
            end else begin
                lat = n - 1;                   // first negedge after the sampling edge counts 1
                assert (rdata == rule_value(a)) else report_value(name, rule_value(a), rdata);
                repeat (hold) @(negedge clk);  // processor keeps req high past ack
                req  = 1'b0;
                n    = 0;
                seen = 1'b1;
                while (seen && n < TIMEOUT_CYCLES) begin
                    @(negedge clk);
                    n++;
                    seen = ack;
                end
                if (seen) begin
                    timeout_errors++;
                    aborted = 1'b1;
                    $display("%s: ack still high %0d cycles after req fell", name, n);
                end else begin
                    assert (n == 1) else report_latency({name, "_release"}, 1, n);
                end
            end
        end
    endtask

    // handshake monitor sampled on the rising edge where req and ack are both settled
    always @(posedge clk) begin
        if (rst_q) begin
            assert (ack === 1'b0) else begin
                protocol_errors++;
                $display("ack is not low after a reset edge");
            end
        end else begin
            if (ack && !ack_q) begin
                assert (req_q) else begin
                    protocol_errors++;
                    $display("ack rose while req was low");
                end
            end
            if (ack_q && !req_q) begin
                assert (!ack) else begin
                    protocol_errors++;
                    $display("ack stayed high more than one cycle after req fell");
                end
            end
            if (ack_q && req_q) begin
                assert (ack) else begin
                    protocol_errors++;
                    $display("ack dropped while req was still high");
                end
            end
            if (ack && ack_q) begin
                assert (rdata == rdata_q) else begin
                    protocol_errors++;
                    $display("rdata changed while ack was high");
                end
            end
        end
        rst_q   <= rst;
        ack_q   <= ack;
        req_q   <= req;
        rdata_q <= rdata;
    end

    initial begin
        int               lat;
        int               hits;
        int               misses;
        cache_pkg::addr_t a_cold;
        cache_pkg::addr_t a_near;
        cache_pkg::addr_t a_conf;
        cache_pkg::addr_t a_rand;
        hits   = 0;
        misses = 0;
        rst    = 1'b1;
        req    = 1'b0;
        addr   = '0;
        repeat (4) @(negedge clk);             // four reset cycles
        assert (ack === 1'b0) else begin
            protocol_errors++;
            $display("ack is not low during reset");
        end
        rst = 1'b0;
        @(negedge clk);
        assert (ack === 1'b0) else begin
            protocol_errors++;
            $display("ack is not low right after reset");
        end

        rng    = xorshift32(rng);
        a_cold = rng[15:0];
        read_word("cold_miss", a_cold, 0, lat);
        if (!aborted) begin
            assert (lat >= MISS_MIN) else report_latency("cold_miss_latency", MISS_MIN, lat);
        end

        a_near = a_cold ^ 16'h0006;            // another word of the same block
        read_word("hit_after_fill", a_near, 5, lat);
        if (!aborted) begin
            assert (lat == HIT_LATENCY) else report_latency("hit_latency", HIT_LATENCY, lat);
        end

        a_conf = a_cold ^ cache_pkg::addr_t'(1 << TAG_LSB);  // same index but another tag
        read_word("conflict_miss", a_conf, 1, lat);
        if (!aborted) begin
            assert (lat >= MISS_MIN) else report_latency("conflict_latency", MISS_MIN, lat);
        end
        read_word("evicted_miss", a_cold, 0, lat);
        if (!aborted) begin
            assert (lat >= MISS_MIN) else report_latency("evicted_latency", MISS_MIN, lat);
        end

        // 512 bytes is 32 blocks over 16 lines, so hits and conflicts both show up
        for (int i = 0; i < 60; i++) begin
            rng    = xorshift32(rng);
            a_rand = 16'h3000 + {7'd0, rng[8:0]};
            read_word("random_read", a_rand, rng[17:16], lat);
            if (lat == HIT_LATENCY) begin
                hits++;
            end else if (lat >= MISS_MIN) begin
                misses++;
            end else if (lat >= 0) begin
                report_latency("random_latency", MISS_MIN, lat);
            end
        end
        if (!aborted) begin
            assert (hits > 0 && misses > 0) else begin
                value_errors++;
                $display("random traffic did not mix hits and misses (%0d hits, %0d misses)",
                         hits, misses);
            end
        end

        $display("reads done: %0d value errors, %0d handshake errors, %0d timeouts",
                 value_errors, protocol_errors, timeout_errors);
        if (value_errors + protocol_errors + timeout_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
design/cache_pkg.sv
design/cache_fill_fsm.sv
design/tag_array.sv
design/data_array.sv
design/main_memory.sv
design/cache_controller.sv
design/cache_top.sv
test/cache_tb.sv

// File: Bender.yml
package:
  name: cache

sources:
  # package first, then leaf modules, then the top level
  - design/cache_pkg.sv
  - design/cache_fill_fsm.sv
  - design/tag_array.sv
  - design/data_array.sv
  - design/main_memory.sv
  - design/cache_controller.sv
  - design/cache_top.sv

  - target: test
    files:
      - test/cache_tb.sv
